//--- files.f
rtl/axi_pkg.sv
rtl/cache_pkg.sv
rtl/cache_ctrl.sv
rtl/tag_array.sv
rtl/data_sram.sv
rtl/refill_buffer.sv
rtl/icache_top.sv
tests/tb_axi_mem.sv
tests/tb_icache.sv

//--- rtl/axi_pkg.sv
package axi_pkg;

  // read address channel payload, valid/ready travel beside it
  typedef struct packed {
    logic [31:0] addr;
    logic [3:0]  id;
    logic [7:0]  len;
    logic [2:0]  size;
    logic [1:0]  burst;
  } ar_chan_t;

  // read data channel payload
  typedef struct packed {
    logic [63:0] data;
    logic [1:0]  resp;
    logic        last;
    logic [3:0]  id;
  } r_chan_t;

  // burst type
  localparam logic [1:0] BURST_INCR = 2'b01;

  // response code
  localparam logic [1:0] RESP_OKAY = 2'b00;

  // 8 bytes per beat, one full data bus word
  localparam logic [2:0] SIZE_8B = 3'b011;

endpackage

//--- rtl/cache_ctrl.sv
module cache_ctrl #(
  parameter logic [3:0] AXI_ID = 4'd0
) (
  input  logic                          clock,
  input  logic                          arst_n,
  input  logic                          req_valid,
  input  cache_pkg::core_req_t          req,
  input  logic                          flush,
  input  logic                          tag_hit,
  input  logic                          tag_valid,
  input  cache_pkg::line_t              sram_line,
  input  cache_pkg::line_t              refill_line,
  input  logic                          line_done,
  input  logic                          line_err,
  input  logic                          ar_ready,
  output logic                          busy,
  output logic                          rsp_valid,
  output cache_pkg::core_rsp_t          rsp,
  output logic                          lookup_en,
  output logic [cache_pkg::INDEX_W-1:0] index,
  output logic                          sram_cen,
  output logic                          fill_en,
  output logic                          flush_en,
  output logic                          refill_start,
  output logic                          ar_valid,
  output axi_pkg::ar_chan_t             ar,
  output logic                          r_ready,
  output logic                          sel_refill
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_COMPARE,
    ST_ADDRESS,
    ST_DATA,
    ST_INSTALL,
    ST_RESPOND
  } state_t;

  state_t           state;
  state_t           state_nxt;
  cache_pkg::addr_u addr_q;
  logic             err_q;
  logic             miss;
  cache_pkg::line_t line_sel;

  assign miss = !(tag_valid && tag_hit);

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE:    if (req_valid) state_nxt = ST_COMPARE;
      ST_COMPARE: state_nxt = miss ? ST_ADDRESS : ST_RESPOND;
      ST_ADDRESS: if (ar_ready) state_nxt = ST_DATA;
      ST_DATA:    if (line_done) state_nxt = ST_INSTALL;
      ST_INSTALL: state_nxt = ST_RESPOND;
      ST_RESPOND: state_nxt = ST_IDLE;
      default:    state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state      <= ST_IDLE;
      err_q      <= 1'b0;
      sel_refill <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state == ST_COMPARE) begin
        sel_refill <= miss;
        err_q      <= 1'b0;
      end
      // error of the whole burst, last beat included
      if (state == ST_DATA && line_done) begin
        err_q <= line_err;
      end
    end
  end

  // request address, held for the whole transaction
  always_ff @(posedge clock) begin
    if (lookup_en) begin
      addr_q <= req.addr;
    end
  end

  assign busy         = state != ST_IDLE;
  assign lookup_en    = req_valid && !busy;
  assign flush_en     = flush && !busy;
  assign refill_start = state == ST_COMPARE && miss;
  assign ar_valid     = state == ST_ADDRESS;
  assign r_ready      = state == ST_DATA;
  // a failed refill leaves the set untouched
  assign fill_en      = state == ST_INSTALL && !err_q;
  assign sram_cen     = lookup_en || fill_en;
  assign rsp_valid    = state == ST_RESPOND;

  // incoming index on lookup, stored one afterwards
  assign index = busy ? addr_q.fields.index : req.addr.fields.index;

  always_comb begin
    ar.addr  = {addr_q.fields.tag, addr_q.fields.index, {cache_pkg::OFFSET_W{1'b0}}};
    ar.id    = AXI_ID;
    ar.len   = 8'd1;
    ar.size  = axi_pkg::SIZE_8B;
    ar.burst = axi_pkg::BURST_INCR;
  end

  // offset bit 3 picks the upper or lower beat
  assign line_sel = sel_refill ? refill_line : sram_line;
  assign rsp.data = addr_q.fields.offset[cache_pkg::OFFSET_W-1] ? line_sel[127:64]
                                                                 : line_sel[63:0];
  assign rsp.err  = err_q;

  // core must wait for busy to drop before the next fetch
  a_no_req_when_busy: assert property (
    @(posedge clock) disable iff (!arst_n) busy |-> !req_valid
  );

  a_ar_stable: assert property (
    @(posedge clock) disable iff (!arst_n)
      ar_valid && !ar_ready |=> ar_valid && $stable(ar)
  );

  a_rsp_one_cycle: assert property (
    @(posedge clock) disable iff (!arst_n) rsp_valid |=> !rsp_valid
  );

endmodule

//--- rtl/cache_pkg.sv
package cache_pkg;

  // 16-byte lines, 64 sets, rest of the 32-bit address is tag
  localparam int OFFSET_W = 4;
  localparam int INDEX_W  = 6;
  localparam int TAG_W    = 22;

  // one cache line, two 64-bit beats
  typedef logic [127:0] line_t;

  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
  } addr_fields_t;

  // same address word, seen raw or split for lookup
  typedef union packed {
    logic [31:0]  word;
    addr_fields_t fields;
  } addr_u;

  // core fetch request
  typedef struct packed {
    addr_u addr;
  } core_req_t;

  // core fetch response
  typedef struct packed {
    logic [63:0] data;
    logic        err;
  } core_rsp_t;

endpackage

//--- rtl/data_sram.sv
module data_sram (
  input  logic                          clock,
  input  logic                          cen,
  input  logic                          wen,
  input  logic [cache_pkg::INDEX_W-1:0] addr,
  input  cache_pkg::line_t              wmask,
  input  cache_pkg::line_t              wdata,
  output cache_pkg::line_t              rdata
);

  localparam int DEPTH = 1 << cache_pkg::INDEX_W;

  cache_pkg::line_t mem [DEPTH];

  // single port, write or read per enabled cycle
  always_ff @(posedge clock) begin
    if (cen) begin
      if (wen) begin
        // bitwise mask, set bits take wdata
        mem[addr] <= (mem[addr] & ~wmask) | (wdata & wmask);
      end else begin
        rdata <= mem[addr];
      end
    end
  end

  // rdata holds its value until the next read

endmodule

//--- rtl/icache_top.sv
module icache_top #(
  parameter logic [3:0] AXI_ID = 4'd0
) (
  input  logic                 clock,
  input  logic                 arst_n,
  input  logic                 req_valid,
  input  cache_pkg::core_req_t req,
  input  logic                 flush,
  output logic                 busy,
  output logic                 rsp_valid,
  output cache_pkg::core_rsp_t rsp,
  output logic                 ar_valid,
  input  logic                 ar_ready,
  output axi_pkg::ar_chan_t    ar,
  input  logic                 r_valid,
  output logic                 r_ready,
  input  axi_pkg::r_chan_t     r
);

  logic                          lookup_en;
  logic [cache_pkg::INDEX_W-1:0] index;
  logic                          sram_cen;
  logic                          fill_en;
  logic                          flush_en;
  logic                          refill_start;
  logic                          tag_hit;
  logic                          tag_valid;
  cache_pkg::line_t              sram_line;
  cache_pkg::line_t              refill_line;
  logic                          line_done;
  logic                          line_err;

  cache_ctrl #(
    .AXI_ID (AXI_ID)
  ) u_ctrl (
    .clock        (clock),
    .arst_n       (arst_n),
    .req_valid    (req_valid),
    .req          (req),
    .flush        (flush),
    .tag_hit      (tag_hit),
    .tag_valid    (tag_valid),
    .sram_line    (sram_line),
    .refill_line  (refill_line),
    .line_done    (line_done),
    .line_err     (line_err),
    .ar_ready     (ar_ready),
    .busy         (busy),
    .rsp_valid    (rsp_valid),
    .rsp          (rsp),
    .lookup_en    (lookup_en),
    .index        (index),
    .sram_cen     (sram_cen),
    .fill_en      (fill_en),
    .flush_en     (flush_en),
    .refill_start (refill_start),
    .ar_valid     (ar_valid),
    .ar           (ar),
    .r_ready      (r_ready),
    .sel_refill   ()
  );

  tag_array u_tags (
    .clock      (clock),
    .arst_n     (arst_n),
    .lookup_en  (lookup_en),
    .index      (index),
    .lookup_tag (req.addr.fields.tag),
    .fill_en    (fill_en),
    .flush_en   (flush_en),
    .tag_hit    (tag_hit),
    .tag_valid  (tag_valid)
  );

  // whole-line writes only
  data_sram u_data (
    .clock (clock),
    .cen   (sram_cen),
    .wen   (fill_en),
    .addr  (index),
    .wmask ('1),
    .wdata (refill_line),
    .rdata (sram_line)
  );

  refill_buffer #(
    .AXI_ID (AXI_ID)
  ) u_refill (
    .clock        (clock),
    .arst_n       (arst_n),
    .refill_start (refill_start),
    .r_valid      (r_valid),
    .r_ready      (r_ready),
    .r            (r),
    .line         (refill_line),
    .line_done    (line_done),
    .line_err     (line_err)
  );

endmodule

//--- rtl/refill_buffer.sv
module refill_buffer #(
  parameter logic [3:0] AXI_ID = 4'd0
) (
  input  logic             clock,
  input  logic             arst_n,
  input  logic             refill_start,
  input  logic             r_valid,
  input  logic             r_ready,
  input  axi_pkg::r_chan_t r,
  output cache_pkg::line_t line,
  output logic             line_done,
  output logic             line_err
);

  logic beat;
  logic beat_bad;
  logic cnt_q;
  logic err_q;

  assign beat     = r_valid && r_ready;
  // bad response or a beat meant for another id
  assign beat_bad = (r.resp != axi_pkg::RESP_OKAY) || (r.id != AXI_ID);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      cnt_q <= 1'b0;
      err_q <= 1'b0;
    end else if (refill_start) begin
      cnt_q <= 1'b0;
      err_q <= 1'b0;
    end else if (beat) begin
      cnt_q <= ~cnt_q;
      err_q <= err_q || beat_bad;
    end
  end

  // beat 0 fills the low half, beat 1 the high half
  always_ff @(posedge clock) begin
    if (beat) begin
      if (cnt_q) begin
        line[127:64] <= r.data;
      end else begin
        line[63:0] <= r.data;
      end
    end
  end

  assign line_done = beat && r.last;
  assign line_err  = err_q || (beat && beat_bad);

  // two-beat burst, rlast marks the second one
  a_last_on_second: assert property (
    @(posedge clock) disable iff (!arst_n) beat && r.last |-> cnt_q
  );

endmodule

//--- rtl/tag_array.sv
module tag_array (
  input  logic                          clock,
  input  logic                          arst_n,
  input  logic                          lookup_en,
  input  logic [cache_pkg::INDEX_W-1:0] index,
  input  logic [cache_pkg::TAG_W-1:0]   lookup_tag,
  input  logic                          fill_en,
  input  logic                          flush_en,
  output logic                          tag_hit,
  output logic                          tag_valid
);

  localparam int SETS = 1 << cache_pkg::INDEX_W;

  logic [SETS-1:0]               valid_q;
  logic [cache_pkg::TAG_W-1:0]   tag_mem [SETS];
  logic [cache_pkg::TAG_W-1:0]   tag_rd;
  logic [cache_pkg::TAG_W-1:0]   tag_q;
  logic [cache_pkg::INDEX_W-1:0] index_q;

  // valid bits live in flops so a flush clears all sets at once
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
    end else if (flush_en) begin
      valid_q <= '0;
    end else if (fill_en) begin
      valid_q[index_q] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (lookup_en) begin
      tag_rd  <= tag_mem[index];
      tag_q   <= lookup_tag;
      index_q <= index;
    end
    // fill reuses the tag and set captured at lookup
    if (fill_en) begin
      tag_mem[index_q] <= tag_q;
    end
  end

  // compare cycle
  assign tag_hit   = tag_rd == tag_q;
  assign tag_valid = valid_q[index_q];

  a_no_fill_and_flush: assert property (
    @(posedge clock) disable iff (!arst_n) !(fill_en && flush_en)
  );

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_icache -o sim_icache

if ./obj_dir/sim_icache 2>&1 | tee /dev/stderr | grep "Simulation completed successfully" > /dev/null; then
  echo "run.sh: PASS"
  exit 0
else
  echo "run.sh: FAIL"
  exit 1
fi

//--- tests/tb_axi_mem.sv
module tb_axi_mem (
  input  logic              clock,
  input  logic              arst_n,
  input  logic              ar_valid,
  output logic              ar_ready,
  input  axi_pkg::ar_chan_t ar,
  output logic              r_valid,
  input  logic              r_ready,
  output axi_pkg::r_chan_t  r,
  output int                ar_count,
  output axi_pkg::ar_chan_t last_ar
);

  logic [31:0] rng;
  logic [1:0]  ar_wait;
  logic [1:0]  r_wait;
  logic        pend;
  logic        beat;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // beat b of the burst, data from the beat address, SLVERR in the f region
  function automatic axi_pkg::r_chan_t make_beat(input axi_pkg::ar_chan_t a, input logic b);
    axi_pkg::r_chan_t t;
    logic [31:0]      ba;
    ba     = a.addr + (b ? 32'd8 : 32'd0);
    t.data = {ba, ba} ^ 64'h5a5a_0000_a5a5_0000;
    t.resp = (a.addr[31:28] == 4'hf) ? 2'b10 : 2'b00;
    t.last = b;
    t.id   = a.id;
    return t;
  endfunction

  always @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      ar_ready <= 1'b0;
      r_valid  <= 1'b0;
      r        <= '0;
      rng      <= 32'hbfd5;
      ar_wait  <= 2'd0;
      r_wait   <= 2'd0;
      pend     <= 1'b0;
      beat     <= 1'b0;
      ar_count <= 0;
      last_ar  <= '0;
    end else begin
      rng <= xorshift(rng);
      // address channel, ready comes after a random stall
      if (ar_valid && ar_ready) begin
        ar_ready <= 1'b0;
        last_ar  <= ar;
        ar_count <= ar_count + 1;
        pend     <= 1'b1;
        beat     <= 1'b0;
        r_wait   <= rng[1:0];
      end else if (ar_valid && !pend) begin
        if (ar_wait == 2'd0) begin
          ar_ready <= 1'b1;
        end else begin
          ar_wait <= ar_wait - 2'd1;
        end
      end
      // data channel, gaps between beats
      if (pend) begin
        if (r_valid && r_ready) begin
          r_valid <= 1'b0;
          beat    <= 1'b1;
          r_wait  <= rng[3:2];
          if (beat) begin
            pend    <= 1'b0;
            ar_wait <= rng[5:4];
          end
        end else if (!r_valid) begin
          if (r_wait == 2'd0) begin
            r_valid <= 1'b1;
            r       <= make_beat(last_ar, beat);
          end else begin
            r_wait <= r_wait - 2'd1;
          end
        end
      end
    end
  end

endmodule

//--- tests/tb_icache.sv
module tb_icache;

  localparam int TIMEOUT = 200;
  localparam int NSTIM   = 15;

  // one table row, a flush or a read with its expected outcome
  typedef struct packed {
    logic        flush_op;
    logic [31:0] addr;
    logic        miss;
    logic        err;
  } stim_t;

  logic                 clock;
  logic                 arst_n;
  logic                 req_valid;
  cache_pkg::core_req_t req;
  logic                 flush;
  logic                 busy;
  logic                 rsp_valid;
  cache_pkg::core_rsp_t rsp;
  logic                 ar_valid;
  logic                 ar_ready;
  axi_pkg::ar_chan_t    ar;
  logic                 r_valid;
  logic                 r_ready;
  axi_pkg::r_chan_t     r;
  int                   ar_count;
  axi_pkg::ar_chan_t    last_ar;
  stim_t                stim [NSTIM];
  int                   idx;

  always #5 clock = ~clock;

  icache_top #(
    .AXI_ID (4'd0)
  ) DUT (
    .clock     (clock),
    .arst_n    (arst_n),
    .req_valid (req_valid),
    .req       (req),
    .flush     (flush),
    .busy      (busy),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .ar_valid  (ar_valid),
    .ar_ready  (ar_ready),
    .ar        (ar),
    .r_valid   (r_valid),
    .r_ready   (r_ready),
    .r         (r)
  );

  tb_axi_mem u_mem (
    .clock    (clock),
    .arst_n   (arst_n),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .ar       (ar),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .r        (r),
    .ar_count (ar_count),
    .last_ar  (last_ar)
  );

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "stopping after the first error");
  endtask

  task automatic check_rsp(input cache_pkg::core_rsp_t got, input cache_pkg::core_rsp_t exp);
    if (got !== exp) begin
      fail_run($sformatf("[FAIL] rsp: got data=%h err=%h expected data=%h err=%h",
                         got.data, got.err, exp.data, exp.err));
    end
  endtask

  task automatic check_ar(input axi_pkg::ar_chan_t got, input axi_pkg::ar_chan_t exp);
    if (got !== exp) begin
      fail_run($sformatf("[FAIL] ar: got %h expected %h", got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("[FAIL] %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      fail_run($sformatf("[FAIL] %s: got %h expected %h", name, got, exp));
    end
  endtask

  // beat address with both halves xor the memory pattern
  function automatic cache_pkg::core_rsp_t expect_rsp(input logic [31:0] addr, input logic err);
    cache_pkg::core_rsp_t e;
    logic [31:0]          ba;
    ba     = {addr[31:3], 3'b000};
    e.data = {ba, ba} ^ 64'h5a5a_0000_a5a5_0000;
    e.err  = err;
    return e;
  endfunction

  // line base, two beats of 8 bytes, INCR
  function automatic axi_pkg::ar_chan_t expect_ar(input logic [31:0] addr);
    axi_pkg::ar_chan_t e;
    e.addr  = {addr[31:4], 4'h0};
    e.id    = 4'd0;
    e.len   = 8'd1;
    e.size  = 3'b011;
    e.burst = 2'b01;
    return e;
  endfunction

  task automatic load_stim();
    // cold miss, then hits on both halves of the line
    stim[0]  = '{1'b0, 32'h0000_1000, 1'b1, 1'b0};
    stim[1]  = '{1'b0, 32'h0000_1000, 1'b0, 1'b0};
    stim[2]  = '{1'b0, 32'h0000_1008, 1'b0, 1'b0};
    stim[3]  = '{1'b0, 32'h0000_1004, 1'b0, 1'b0};
    // set 0 with another tag evicts the first line
    stim[4]  = '{1'b0, 32'h0040_1000, 1'b1, 1'b0};
    stim[5]  = '{1'b0, 32'h0040_1008, 1'b0, 1'b0};
    stim[6]  = '{1'b0, 32'h0000_1008, 1'b1, 1'b0};
    stim[7]  = '{1'b0, 32'h0000_2ab8, 1'b1, 1'b0};
    stim[8]  = '{1'b1, 32'h0000_0000, 1'b0, 1'b0};
    stim[9]  = '{1'b0, 32'h0000_1000, 1'b1, 1'b0};
    stim[10] = '{1'b0, 32'h0000_2ab0, 1'b1, 1'b0};
    // error region never gets installed
    stim[11] = '{1'b0, 32'hf000_0040, 1'b1, 1'b1};
    stim[12] = '{1'b0, 32'hf000_0040, 1'b1, 1'b1};
    stim[13] = '{1'b0, 32'hf000_0048, 1'b1, 1'b1};
    stim[14] = '{1'b0, 32'h0000_2ab8, 1'b0, 1'b0};
  endtask

  task automatic do_flush();
    flush = 1'b1;
    @(posedge clock);
    #1;
    flush = 1'b0;
  endtask

  // starts and ends one time unit after an edge with busy low
  task automatic do_read(input stim_t s);
    int ars;
    int edges;
    ars           = ar_count;
    req_valid     = 1'b1;
    req.addr.word = s.addr;
    @(posedge clock);
    #1;
    req_valid = 1'b0;
    edges     = 0;
    while (!rsp_valid) begin
      if (edges == TIMEOUT) begin
        fail_run($sformatf("no response within %0d cycles for address %h", TIMEOUT, s.addr));
      end
      @(posedge clock);
      #1;
      edges++;
    end
    check_rsp(rsp, expect_rsp(s.addr, s.err));
    // the core takes the pulse on the following edge
    if (!s.miss) begin
      check_count("hit latency", edges + 1, 2);
    end
    check_count("ar transfers", ar_count - ars, s.miss ? 1 : 0);
    if (s.miss) begin
      check_ar(last_ar, expect_ar(s.addr));
    end
    @(posedge clock);
    #1;
    check_flag("busy", busy, 1'b0);
    check_flag("r_ready", r_ready, 1'b0);
  endtask

  initial begin
    clock     = 1'b0;
    arst_n    = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    flush     = 1'b0;
    load_stim();
    repeat (10) @(posedge clock);
    #1;
    arst_n = 1'b1;
    check_flag("busy", busy, 1'b0);
    check_flag("rsp_valid", rsp_valid, 1'b0);
    check_flag("ar_valid", ar_valid, 1'b0);
    check_flag("r_ready", r_ready, 1'b0);
    for (idx = 0; idx < NSTIM; idx++) begin
      if (stim[idx].flush_op) begin
        do_flush();
      end else begin
        do_read(stim[idx]);
      end
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule
